//--- sources.f
design/wb_pkg.sv
design/stage_reg.sv
design/pipe_ctrl.sv
design/mem_access.sv
design/reg_file.sv
design/special_regs.sv
design/wb_top.sv
verif/wb_tb.sv

//--- run.sh
#!/bin/sh
# build and run the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module wb_tb \
    -f sources.f \
    -o wb_sim

./obj_dir/wb_sim

//--- verif/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;

    import wb_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int AHI        = $clog2(DMEM_WORDS) + 1;

    typedef struct {
        string      name;
        ex_mem_t    ex;
        logic       sx;
        logic       sm;
        exc_t       exc;
        logic       eret;
        logic [4:0] ra;
    } row_t;

    logic        clk;
    logic        rst_n;
    ex_mem_t     ex_result;
    logic        stall_req_ex;
    logic        stall_req_mem;
    exc_t        exc;
    logic        eret;
    logic [4:0]  rd_addr_a;
    logic [4:0]  rd_addr_b;
    logic [4:0]  cp0_rd_addr;
    logic [31:0] rd_data_a;
    logic [31:0] rd_data_b;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] cp0_rd_data;
    logic        exl;
    logic        flush;

    row_t        rows[64];
    int          n_rows = 0;
    logic [31:0] rng_state = 32'hfebea0f9;

    // reference model of the back end
    logic [31:0] m_regs[32];
    logic [31:0] m_ram[DMEM_WORDS];
    logic [31:0] m_hi;
    logic [31:0] m_lo;
    logic [31:0] m_epc;
    logic [31:0] m_bad;
    logic [4:0]  m_code;
    logic        m_exl;
    logic        m_taken;
    ex_mem_t     m_exmem;
    mem_wb_t     m_memwb;

    wb_top #(.DMEM_WORDS(DMEM_WORDS)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "bit mismatch on %s", name);
        end
    endtask

    task automatic add_row(input string name, input ex_mem_t ex, input logic [4:0] ra);
        rows[n_rows].name = name;
        rows[n_rows].ex   = ex;
        rows[n_rows].sx   = 1'b0;
        rows[n_rows].sm   = 1'b0;
        rows[n_rows].exc  = '0;
        rows[n_rows].eret = 1'b0;
        rows[n_rows].ra   = ra;
        n_rows++;
    endtask

    task automatic alu_row(input string name, input logic [4:0] rd);
        ex_mem_t e;
        e            = '0;
        e.we         = 1'b1;
        e.waddr      = rd;
        e.alu_result = next_random();
        add_row(name, e, rd);
    endtask

    task automatic mem_row(input string name, input mem_op_e op, input logic [4:0] rd,
                           input logic [31:0] addr);
        ex_mem_t e;
        e            = '0;
        e.mem_op     = op;
        e.alu_result = addr;
        e.store_data = next_random();
        e.we         = op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
        e.waddr      = rd;
        add_row(name, e, rd);
    endtask

    task automatic special_row(input string name, input logic whilo, input logic cp0_we,
                               input logic [4:0] cp0_addr, input logic [31:0] cp0_data);
        ex_mem_t e;
        e           = '0;
        e.whilo     = whilo;
        e.hi        = next_random();
        e.lo        = next_random();
        e.cp0_we    = cp0_we;
        e.cp0_waddr = cp0_addr;
        e.cp0_wdata = cp0_data;
        add_row(name, e, 5'd0);
    endtask

    task automatic stall_last(input logic sx, input logic sm);
        rows[n_rows-1].sx = sx;
        rows[n_rows-1].sm = sm;
    endtask

    // upstream keeps presenting the same instruction while stalled
    task automatic repeat_row(input logic sx, input logic sm);
        rows[n_rows] = rows[n_rows-1];
        n_rows++;
        stall_last(sx, sm);
    endtask

    task automatic raise_exc(input logic [4:0] code);
        exc_t x;
        x.valid    = 1'b1;
        x.code     = code;
        x.pc       = next_random();
        x.bad_addr = next_random();
        rows[n_rows-1].exc = x;
    endtask

    task automatic build_table();
        alu_row("alu r1", 5'd1);
        alu_row("alu r2", 5'd2);
        alu_row("alu r3", 5'd3);
        alu_row("alu r0 ignored", 5'd0);
        mem_row("sw 0x10", mem_sw, 5'd0, 32'h10);
        rows[n_rows-1].ex.store_data |= 32'h8080_8080;
        mem_row("sw 0x14", mem_sw, 5'd0, 32'h14);
        mem_row("sh 0x12", mem_sh, 5'd0, 32'h12);
        rows[n_rows-1].ex.store_data |= 32'h0000_8000;
        mem_row("sb 0x15", mem_sb, 5'd0, 32'h15);
        mem_row("sb 0x17", mem_sb, 5'd0, 32'h17);
        mem_row("lw 0x10", mem_lw, 5'd6, 32'h10);
        mem_row("lh 0x12", mem_lh, 5'd7, 32'h12);
        mem_row("lhu 0x12", mem_lhu, 5'd8, 32'h12);
        mem_row("lb 0x15", mem_lb, 5'd9, 32'h15);
        mem_row("lbu 0x17", mem_lbu, 5'd10, 32'h17);
        mem_row("lh 0x14", mem_lh, 5'd11, 32'h14);
        mem_row("lbu 0x10", mem_lbu, 5'd12, 32'h10);
        mem_row("lb 0x13", mem_lb, 5'd13, 32'h13);
        mem_row("lhu 0x16", mem_lhu, 5'd14, 32'h16);
        special_row("hilo write", 1'b1, 1'b0, 5'd0, 32'h0);
        special_row("cp0 epc write", 1'b0, 1'b1, cp0_epc, next_random());
        special_row("cp0 cause write", 1'b0, 1'b1, cp0_cause, 32'hffff_ffff);
        special_row("cp0 status read-only bits", 1'b0, 1'b1, cp0_status, 32'hffff_fffd);
        special_row("cp0 badvaddr read-only", 1'b0, 1'b1, cp0_badvaddr, 32'hffff_ffff);
        special_row("cp0 status exl set", 1'b0, 1'b1, cp0_status, 32'h2);
        special_row("cp0 status exl clear", 1'b0, 1'b1, cp0_status, 32'h0);
        // store parked in ex/mem while mem stalls
        mem_row("sw 0x20 under mem stall", mem_sw, 5'd0, 32'h20);
        alu_row("alu r15 mem stall", 5'd15);
        stall_last(1'b0, 1'b1);
        repeat_row(1'b0, 1'b1);
        repeat_row(1'b0, 1'b0);
        // r15 now waits in ex/mem behind a second mem stall
        mem_row("lw 0x20", mem_lw, 5'd16, 32'h20);
        stall_last(1'b0, 1'b1);
        repeat_row(1'b0, 1'b0);
        alu_row("alu r17 ex stall", 5'd17);
        stall_last(1'b1, 1'b0);
        repeat_row(1'b0, 1'b0);
        alu_row("alu r18", 5'd18);
        alu_row("alu r19 squashed", 5'd19);
        alu_row("alu r20 exception", 5'd20);
        raise_exc(exc_adel);
        alu_row("alu r21 back-to-back exception", 5'd21);
        raise_exc(exc_ades);
        alu_row("alu r22", 5'd22);
        alu_row("alu r23", 5'd23);
        alu_row("alu r24 exception under exl", 5'd24);
        raise_exc(exc_ades);
        alu_row("alu r25", 5'd25);
        alu_row("alu r26 eret", 5'd26);
        rows[n_rows-1].eret = 1'b1;
        alu_row("alu r27 after eret", 5'd27);
        alu_row("alu r28", 5'd28);
        alu_row("alu r29", 5'd29);
        alu_row("alu r30 exception after eret", 5'd30);
        raise_exc(exc_adel);
        alu_row("alu r31", 5'd31);
        alu_row("alu r1 again", 5'd1);
    endtask

    function automatic logic accepts(input exc_t x);
        return x.valid && !m_exl && !m_taken;
    endfunction

    // 0 bubble, 1 load, 2 hold
    function automatic int stage_action(input stall_t st, input logic fl, input int idx);
        if (fl || (st[idx] && !st[idx+1]))
            return 0;
        return st[idx] ? 2 : 1;
    endfunction

    function automatic mem_wb_t mem_stage_result(input ex_mem_t e);
        mem_wb_t     o;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = m_ram[e.alu_result[AHI:2]];
        b = 8'(w >> (8 * e.alu_result[1:0]));
        h = 16'(w >> (16 * e.alu_result[1]));
        o = '{waddr: e.waddr, we: e.we, wdata: e.alu_result, hi: e.hi, lo: e.lo,
              whilo: e.whilo, cp0_we: e.cp0_we, cp0_waddr: e.cp0_waddr,
              cp0_wdata: e.cp0_wdata};
        case (e.mem_op)
            mem_lw:  o.wdata = w;
            mem_lh:  o.wdata = 32'($signed(h));
            mem_lhu: o.wdata = {16'h0, h};
            mem_lb:  o.wdata = 32'($signed(b));
            mem_lbu: o.wdata = {24'h0, b};
            default: ;
        endcase
        return o;
    endfunction

    task automatic store_commit(input ex_mem_t e);
        logic [AHI-2:0] idx;
        int             lane;
        idx  = e.alu_result[AHI:2];
        lane = int'(e.alu_result[1:0]);
        case (e.mem_op)
            mem_sw:  m_ram[idx] = e.store_data;
            mem_sh:  m_ram[idx][16*(lane/2) +: 16] = e.store_data[15:0];
            mem_sb:  m_ram[idx][8*lane +: 8] = e.store_data[7:0];
            default: ;
        endcase
    endtask

    // one rising edge with the inputs of row r present before it
    task automatic model_edge(input row_t r);
        stall_t  st;
        logic    acc;
        logic    fl;
        mem_wb_t wb_next;
        int      act;
        st  = r.sm ? 6'b011111 : (r.sx ? 6'b001111 : 6'b000000);
        acc = accepts(r.exc);
        fl  = acc || r.eret;
        if (m_memwb.we && m_memwb.waddr != 5'd0)
            m_regs[m_memwb.waddr] = m_memwb.wdata;
        if (m_memwb.whilo) begin
            m_hi = m_memwb.hi;
            m_lo = m_memwb.lo;
        end
        if (acc) begin
            m_exl  = 1'b1;
            m_code = r.exc.code;
            m_epc  = r.exc.pc;
            m_bad  = r.exc.bad_addr;
        end else begin
            if (m_memwb.cp0_we) begin
                case (m_memwb.cp0_waddr)
                    cp0_status: m_exl  = m_memwb.cp0_wdata[1];
                    cp0_cause:  m_code = m_memwb.cp0_wdata[6:2];
                    cp0_epc:    m_epc  = m_memwb.cp0_wdata;
                    default: ;
                endcase
            end
            if (r.eret)
                m_exl = 1'b0;
        end
        wb_next = mem_stage_result(m_exmem);
        if (!fl && !st[4])
            store_commit(m_exmem);
        act = stage_action(st, fl, 4);
        if (act == 0)
            m_memwb = '0;
        else if (act == 1)
            m_memwb = wb_next;
        act = stage_action(st, fl, 3);
        if (act == 0)
            m_exmem = '0;
        else if (act == 1)
            m_exmem = r.ex;
        m_taken = acc;
    endtask

    function automatic logic [31:0] cp0_expected(input logic [4:0] addr);
        case (addr)
            cp0_badvaddr: return m_bad;
            cp0_status:   return {30'h0, m_exl, 1'b0};
            cp0_cause:    return {25'h0, m_code, 2'b00};
            cp0_epc:      return m_epc;
            default:      return 32'h0;
        endcase
    endfunction

    function automatic logic [4:0] cp0_pick(input int i);
        case (i % 5)
            0:       return cp0_badvaddr;
            1:       return cp0_status;
            2:       return cp0_cause;
            3:       return cp0_epc;
            default: return 5'd3;
        endcase
    endfunction

    task automatic check_outputs(input row_t r);
        logic exp_flush;
        exp_flush = accepts(r.exc) || r.eret;
        check_word({r.name, ": rd_data_a"}, m_regs[rd_addr_a], rd_data_a);
        check_word({r.name, ": rd_data_b"}, m_regs[rd_addr_b], rd_data_b);
        check_word({r.name, ": hi"}, m_hi, hi);
        check_word({r.name, ": lo"}, m_lo, lo);
        check_word({r.name, ": cp0_rd_data"}, cp0_expected(cp0_rd_addr), cp0_rd_data);
        check_bit({r.name, ": exl"}, m_exl, exl);
        check_bit({r.name, ": flush"}, exp_flush, flush);
    endtask

    initial begin
        wait (n_rows > 0);
        #((n_rows + 20) * 40);
        $display("watchdog: run did not finish within %0d clock cycles", n_rows + 20);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        row_t idle;
        row_t cur;
        rst_n         <= 1'b0;
        ex_result     <= '0;
        stall_req_ex  <= 1'b0;
        stall_req_mem <= 1'b0;
        exc           <= '0;
        eret          <= 1'b0;
        rd_addr_a     <= 5'd0;
        rd_addr_b     <= 5'd0;
        cp0_rd_addr   <= 5'd0;
        for (int k = 0; k < 32; k++)
            m_regs[k] = '0;
        for (int k = 0; k < DMEM_WORDS; k++)
            m_ram[k] = '0;
        m_hi    = '0;
        m_lo    = '0;
        m_epc   = '0;
        m_bad   = '0;
        m_code  = '0;
        m_exl   = 1'b0;
        m_taken = 1'b0;
        m_exmem = '0;
        m_memwb = '0;
        idle.name = "drain";
        idle.ex   = '0;
        idle.sx   = 1'b0;
        idle.sm   = 1'b0;
        idle.exc  = '0;
        idle.eret = 1'b0;
        idle.ra   = 5'd0;
        build_table();
        cur = idle;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_rows + 4; i++) begin
            @(posedge clk);
            model_edge(cur);
            if (i < n_rows)
                cur = rows[i];
            else
                cur = idle;
            ex_result     <= cur.ex;
            stall_req_ex  <= cur.sx;
            stall_req_mem <= cur.sm;
            exc           <= cur.exc;
            eret          <= cur.eret;
            rd_addr_a     <= cur.ra;
            cp0_rd_addr   <= cp0_pick(i);
            // port b follows the destination of three rows back
            if (i >= 3 && i - 3 < n_rows)
                rd_addr_b <= rows[i-3].ra;
            else
                rd_addr_b <= 5'd0;
            @(negedge clk);
            check_outputs(cur);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- design/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::ex_mem_t ex_result,
    input  logic            stall_req_ex,
    input  logic            stall_req_mem,
    input  wb_pkg::exc_t    exc,
    input  logic            eret,
    input  logic [4:0]      rd_addr_a,
    input  logic [4:0]      rd_addr_b,
    input  logic [4:0]      cp0_rd_addr,
    output logic [31:0]     rd_data_a,
    output logic [31:0]     rd_data_b,
    output logic [31:0]     hi,
    output logic [31:0]     lo,
    output logic [31:0]     cp0_rd_data,
    output logic            exl,
    output logic            flush
);

    import wb_pkg::*;

    stall_t  stall;
    exc_t    exc_commit;
    logic    eret_commit;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    pipe_ctrl u_pipe_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_req_ex  (stall_req_ex),
        .stall_req_mem (stall_req_mem),
        .exc           (exc),
        .eret          (eret),
        .exl           (exl),
        .stall         (stall),
        .flush         (flush),
        .exc_commit    (exc_commit),
        .eret_commit   (eret_commit)
    );

    stage_reg #(.payload_t(ex_mem_t), .STAGE(3)) ex_mem_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (ex_result),
        .q     (ex_mem_q)
    );

    mem_access #(.DMEM_WORDS(DMEM_WORDS)) u_mem_access (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .flush   (flush),
        .ex_in   (ex_mem_q),
        .mem_out (mem_wb_d)
    );

    stage_reg #(.payload_t(mem_wb_t), .STAGE(4)) mem_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // writeback is just the mem/wb fields wired to the targets
    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (mem_wb_q.we),
        .waddr   (mem_wb_q.waddr),
        .wdata   (mem_wb_q.wdata),
        .raddr_a (rd_addr_a),
        .raddr_b (rd_addr_b),
        .rdata_a (rd_data_a),
        .rdata_b (rd_data_b)
    );

    special_regs u_special_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .whilo       (mem_wb_q.whilo),
        .hi_in       (mem_wb_q.hi),
        .lo_in       (mem_wb_q.lo),
        .cp0_we      (mem_wb_q.cp0_we),
        .cp0_waddr   (mem_wb_q.cp0_waddr),
        .cp0_wdata   (mem_wb_q.cp0_wdata),
        .exc_commit  (exc_commit),
        .eret_commit (eret_commit),
        .cp0_raddr   (cp0_rd_addr),
        .hi          (hi),
        .lo          (lo),
        .cp0_rdata   (cp0_rd_data),
        .exl         (exl)
    );

endmodule

//--- design/special_regs.sv
`timescale 1ns/1ps

module special_regs (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         whilo,
    input  logic [31:0]  hi_in,
    input  logic [31:0]  lo_in,
    input  logic         cp0_we,
    input  logic [4:0]   cp0_waddr,
    input  logic [31:0]  cp0_wdata,
    input  wb_pkg::exc_t exc_commit,
    input  logic         eret_commit,
    input  logic [4:0]   cp0_raddr,
    output logic [31:0]  hi,
    output logic [31:0]  lo,
    output logic [31:0]  cp0_rdata,
    output logic         exl
);

    import wb_pkg::*;

    logic [4:0]  exc_code;
    logic [31:0] epc;
    logic [31:0] badvaddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (whilo) begin
            hi <= hi_in;
            lo <= lo_in;
        end
    end

    // exception entry overrides any software write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exl      <= 1'b0;
            exc_code <= '0;
            epc      <= '0;
            badvaddr <= '0;
        end else if (exc_commit.valid) begin
            exl      <= 1'b1;
            exc_code <= exc_commit.code;
            epc      <= exc_commit.pc;
            badvaddr <= exc_commit.bad_addr;
        end else begin
            if (cp0_we) begin
                case (cp0_waddr)
                    cp0_status: exl      <= cp0_wdata[1];
                    cp0_cause:  exc_code <= cp0_wdata[6:2];
                    cp0_epc:    epc      <= cp0_wdata;
                    default: begin
                    end
                endcase
            end
            if (eret_commit) begin
                exl <= 1'b0;
            end
        end
    end

    // exl sits at bit 1, exccode at bits 6:2
    always_comb begin
        case (cp0_raddr)
            cp0_badvaddr: cp0_rdata = badvaddr;
            cp0_status:   cp0_rdata = {30'b0, exl, 1'b0};
            cp0_cause:    cp0_rdata = {25'b0, exc_code, 2'b00};
            cp0_epc:      cp0_rdata = epc;
            default:      cp0_rdata = '0;
        endcase
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero, no write bypass
    always_comb begin
        if (raddr_a == 5'd0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == 5'd0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

//--- design/mem_access.sv
`timescale 1ns/1ps

module mem_access #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::stall_t  stall,
    input  logic            flush,
    input  wb_pkg::ex_mem_t ex_in,
    output wb_pkg::mem_wb_t mem_out
);

    import wb_pkg::*;

    localparam int ADDR_BITS = $clog2(DMEM_WORDS);

    logic [31:0] ram [DMEM_WORDS];

    logic [ADDR_BITS-1:0] word_idx;
    logic [1:0]           byte_off;
    logic [31:0]          rd_word;
    logic [7:0]           rd_byte;
    logic [15:0]          rd_half;
    logic [31:0]          load_data;
    logic [3:0]           byte_en;
    logic [31:0]          st_word;
    logic                 store_en;

    // word index wraps at the ram size
    assign word_idx = ex_in.alu_result[ADDR_BITS+1:2];
    assign byte_off = ex_in.alu_result[1:0];

    // store lane masking, data replicated across lanes
    always_comb begin
        byte_en = 4'b0000;
        st_word = ex_in.store_data;
        case (ex_in.mem_op)
            mem_sb: begin
                byte_en = 4'b0001 << byte_off;
                st_word = {4{ex_in.store_data[7:0]}};
            end
            mem_sh: begin
                byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                st_word = {2{ex_in.store_data[15:0]}};
            end
            mem_sw: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // no commit while the stage is frozen or being squashed
    assign store_en = rst_n && !flush && !stall[4] && (byte_en != 4'b0000);

    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    ram[word_idx][8*i +: 8] <= st_word[8*i +: 8];
                end
            end
        end
    end

    // async read, then lane select
    assign rd_word = ram[word_idx];
    assign rd_byte = rd_word[8*byte_off +: 8];
    assign rd_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (ex_in.mem_op)
            mem_lb:  load_data = {{24{rd_byte[7]}}, rd_byte};
            mem_lbu: load_data = {24'b0, rd_byte};
            mem_lh:  load_data = {{16{rd_half[15]}}, rd_half};
            mem_lhu: load_data = {16'b0, rd_half};
            mem_lw:  load_data = rd_word;
            default: load_data = ex_in.alu_result;
        endcase
    end

    always_comb begin
        mem_out           = '0;
        mem_out.waddr     = ex_in.waddr;
        mem_out.we        = ex_in.we;
        mem_out.wdata     = load_data;
        mem_out.hi        = ex_in.hi;
        mem_out.lo        = ex_in.lo;
        mem_out.whilo     = ex_in.whilo;
        mem_out.cp0_we    = ex_in.cp0_we;
        mem_out.cp0_waddr = ex_in.cp0_waddr;
        mem_out.cp0_wdata = ex_in.cp0_wdata;
    end

endmodule

//--- design/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall_req_ex,
    input  logic           stall_req_mem,
    input  wb_pkg::exc_t   exc,
    input  logic           eret,
    input  logic           exl,
    output wb_pkg::stall_t stall,
    output logic           flush,
    output wb_pkg::exc_t   exc_commit,
    output logic           eret_commit
);

    import wb_pkg::*;

    logic exc_accept;
    logic exc_taken_q;

    // mem request freezes everything up to mem, wb keeps draining
    always_comb begin
        stall = '0;
        if (stall_req_mem) begin
            stall[4:0] = 5'b11111;
        end else if (stall_req_ex) begin
            stall[3:0] = 4'b1111;
        end
    end

    // exl is set at the flush edge, the guard covers the edge case right after
    assign exc_accept = exc.valid && !exl && !exc_taken_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exc_taken_q <= 1'b0;
        end else begin
            exc_taken_q <= exc_accept;
        end
    end

    always_comb begin
        exc_commit = '0;
        if (exc_accept) begin
            exc_commit = exc;
        end
    end

    // exception wins over a simultaneous eret
    assign eret_commit = eret && !exc_accept;
    assign flush       = exc_accept || eret;

endmodule

//--- design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0],
    parameter int  STAGE     = 3
) (
    input  logic           clk,
    input  logic           rst_n,
    input  wb_pkg::stall_t stall,
    input  logic           flush,
    input  payload_t       d,
    output payload_t       q
);

    logic stall_here;
    logic stall_next;

    assign stall_here = stall[STAGE];
    assign stall_next = stall[STAGE+1];

    // bubble is the all-zero payload, every enable off
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (stall_here && !stall_next) begin
            // next stage moves on without us
            q <= '0;
        end else if (!stall_here) begin
            q <= d;
        end
    end

endmodule

//--- design/wb_pkg.sv
package wb_pkg;

    // one bit per stage: pc, if, id, ex, mem, wb
    typedef logic [5:0] stall_t;

    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lbu  = 4'd2,
        mem_lh   = 4'd3,
        mem_lhu  = 4'd4,
        mem_lw   = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_e;

    // result leaving the ex stage
    typedef struct packed {
        logic [4:0]  waddr;
        logic        we;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        mem_op_e     mem_op;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        whilo;
        logic        cp0_we;
        logic [4:0]  cp0_waddr;
        logic [31:0] cp0_wdata;
    } ex_mem_t;

    // result leaving the mem stage, consumed by writeback
    typedef struct packed {
        logic [4:0]  waddr;
        logic        we;
        logic [31:0] wdata;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        whilo;
        logic        cp0_we;
        logic [4:0]  cp0_waddr;
        logic [31:0] cp0_wdata;
    } mem_wb_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  code;
        logic [31:0] pc;
        logic [31:0] bad_addr;
    } exc_t;

    // address error on load / store
    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_ades = 5'd5;

    // cp0 register numbers
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

endpackage
